//--- hdl/rv_pkg.sv
package rv_pkg;

  // master-driven AXI4-Lite signals
  typedef struct packed {
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
  } axi_req_t;

  // slave-driven AXI4-Lite signals
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axi_rsp_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word seen through six formats
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_t;

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [11:0] csr_mstatus   = 12'h300;
  localparam logic [11:0] csr_mtvec     = 12'h305;
  localparam logic [11:0] csr_mepc      = 12'h341;
  localparam logic [11:0] csr_mcause    = 12'h342;
  localparam logic [11:0] csr_mvendorid = 12'hF11;
  localparam logic [11:0] csr_marchid   = 12'hF12;

  localparam logic [31:0] reset_pc      = 32'h0000_0000;
  localparam logic [31:0] mstatus_reset = 32'h0000_1800;
  localparam logic [31:0] vendor_id     = 32'h7973_7978;
  localparam logic [31:0] arch_id       = 32'h017D_9F58;

  localparam logic [31:0] cause_ecall      = 32'd11;
  localparam logic [31:0] cause_misaligned = 32'd0;

  // execute unit sequencing
  localparam logic [2:0] st_issue = 3'd0;
  localparam logic [2:0] st_inst  = 3'd1;
  localparam logic [2:0] st_exec  = 3'd2;
  localparam logic [2:0] st_mem   = 3'd3;
  localparam logic [2:0] st_halt  = 3'd4;

endpackage

//--- hdl/reg_file.sv
module reg_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [3:0]  rs1,
  input  logic [3:0]  rs2,
  input  logic [3:0]  rd,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] src1,
  output logic [31:0] src2,
  input  logic [11:0] csr_addr,
  output logic [31:0] csr_rdata,
  input  logic        csr_wen,
  input  logic [31:0] csr_wdata,
  input  logic        trap,
  input  logic [31:0] trap_cause,
  input  logic [31:0] trap_pc,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);

  // x0 has no storage
  logic [31:0] regs [15:1];
  logic [31:0] mstatus;
  logic [31:0] mcause;

  assign src1 = (rs1 == 4'd0) ? 32'd0 : regs[rs1];
  assign src2 = (rs2 == 4'd0) ? 32'd0 : regs[rs2];

  always_ff @(posedge clock) begin
    if (wen && rd != 4'd0) begin
      regs[rd] <= wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= rv_pkg::mstatus_reset;
      mtvec   <= 32'd0;
      mepc    <= 32'd0;
      mcause  <= 32'd0;
    end else if (trap) begin
      mepc   <= trap_pc;
      mcause <= trap_cause;
    end else if (csr_wen) begin
      case (csr_addr)
        rv_pkg::csr_mstatus: mstatus <= csr_wdata;
        rv_pkg::csr_mtvec:   mtvec <= csr_wdata;
        rv_pkg::csr_mepc:    mepc <= csr_wdata;
        rv_pkg::csr_mcause:  mcause <= csr_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (csr_addr)
      rv_pkg::csr_mstatus:   csr_rdata = mstatus;
      rv_pkg::csr_mtvec:     csr_rdata = mtvec;
      rv_pkg::csr_mepc:      csr_rdata = mepc;
      rv_pkg::csr_mcause:    csr_rdata = mcause;
      rv_pkg::csr_mvendorid: csr_rdata = rv_pkg::vendor_id;
      rv_pkg::csr_marchid:   csr_rdata = rv_pkg::arch_id;
      default:               csr_rdata = 32'd0;
    endcase
  end

endmodule

//--- hdl/fetch_unit.sv
module fetch_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             fetch_next,
  input  logic [31:0]      next_pc,
  output logic             inst_valid,
  output rv_pkg::inst_t    inst,
  output rv_pkg::axi_req_t bus_req,
  input  rv_pkg::axi_rsp_t bus_rsp
);

  logic        want;
  logic [31:0] want_pc;
  logic        want_now;
  logic [31:0] pc_now;
  logic        buf_valid;
  logic [31:0] buf_addr;
  logic [31:0] buf_data;
  logic        busy;
  logic        arvalid;
  logic [31:0] fly_addr;
  logic        hit;
  logic        launch;
  logic        r_fire;
  logic [31:0] launch_addr;

  assign want_now = fetch_next | want;
  assign pc_now   = fetch_next ? next_pc : want_pc;
  assign hit      = want_now && buf_valid && (buf_addr == pc_now);
  assign r_fire   = busy && bus_rsp.rvalid;

  // the buffer is only ever full while the bus is quiet, so a hit never meets an R beat
  assign launch      = want_now && !busy;
  assign launch_addr = hit ? buf_addr + 32'd4 : pc_now;

  always_ff @(posedge clock) begin
    if (reset) begin
      want       <= 1'b0;
      buf_valid  <= 1'b0;
      busy       <= 1'b0;
      arvalid    <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= hit;
      if (hit) begin
        want <= 1'b0;
      end else if (fetch_next) begin
        want <= 1'b1;
      end
      if (bus_rsp.arready) begin
        arvalid <= 1'b0;
      end
      if (r_fire) begin
        busy      <= 1'b0;
        buf_valid <= 1'b1;
      end
      // a miss also drops a stale prefetch still sitting in the buffer
      if (launch) begin
        busy      <= 1'b1;
        arvalid   <= 1'b1;
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_next) begin
      want_pc <= next_pc;
    end
    if (r_fire) begin
      buf_addr <= fly_addr;
      buf_data <= bus_rsp.rdata;
    end
    if (launch) begin
      fly_addr <= launch_addr;
    end
    if (hit) begin
      inst <= buf_data;
    end
  end

  always_comb begin
    bus_req         = '0;
    bus_req.araddr  = fly_addr;
    bus_req.arvalid = arvalid;
    bus_req.rready  = busy;
  end

endmodule

//--- hdl/load_store_unit.sv
module load_store_unit (
  input  logic             clock,
  input  logic             reset,
  input  logic             mem_start,
  input  logic             mem_write,
  input  logic [31:0]      mem_addr,
  input  logic [31:0]      mem_wdata,
  output logic             mem_done,
  output logic [31:0]      mem_rdata,
  output rv_pkg::axi_req_t bus_req,
  input  rv_pkg::axi_rsp_t bus_rsp
);

  logic        awvalid;
  logic        wvalid;
  logic        bwait;
  logic        arvalid;
  logic        rwait;
  logic        bready;
  logic        rready;
  logic [31:0] addr;
  logic [31:0] wdata;

  // B and R are only expected once the address side is through
  assign bready = bwait && !awvalid && !wvalid;
  assign rready = rwait && !arvalid;

  always_ff @(posedge clock) begin
    if (reset) begin
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      bwait    <= 1'b0;
      arvalid  <= 1'b0;
      rwait    <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      if (mem_start && mem_write) begin
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bwait   <= 1'b1;
      end
      if (mem_start && !mem_write) begin
        arvalid <= 1'b1;
        rwait   <= 1'b1;
      end
      // AW and W may be taken in either order
      if (awvalid && bus_rsp.awready) begin
        awvalid <= 1'b0;
      end
      if (wvalid && bus_rsp.wready) begin
        wvalid <= 1'b0;
      end
      if (bready && bus_rsp.bvalid) begin
        bwait    <= 1'b0;
        mem_done <= 1'b1;
      end
      if (arvalid && bus_rsp.arready) begin
        arvalid <= 1'b0;
      end
      if (rready && bus_rsp.rvalid) begin
        rwait    <= 1'b0;
        mem_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_start) begin
      addr  <= mem_addr;
      wdata <= mem_wdata;
    end
    if (rready && bus_rsp.rvalid) begin
      mem_rdata <= bus_rsp.rdata;
    end
  end

  always_comb begin
    bus_req.awaddr  = addr;
    bus_req.awvalid = awvalid;
    bus_req.wdata   = wdata;
    bus_req.wstrb   = 4'hF;
    bus_req.wvalid  = wvalid;
    bus_req.bready  = bready;
    bus_req.araddr  = addr;
    bus_req.arvalid = arvalid;
    bus_req.rready  = rready;
  end

endmodule

//--- hdl/axi_lite_arbiter.sv
module axi_lite_arbiter (
  input  logic             clock,
  input  logic             reset,
  input  rv_pkg::axi_req_t fetch_req,
  output rv_pkg::axi_rsp_t fetch_rsp,
  input  rv_pkg::axi_req_t lsu_req,
  output rv_pkg::axi_rsp_t lsu_rsp,
  output rv_pkg::axi_req_t mem_req,
  input  rv_pkg::axi_rsp_t mem_rsp
);

  logic owned;
  logic owner_lsu;
  logic lsu_active;
  logic fetch_active;
  logic sel_lsu;
  logic sel_fetch;
  logic resp_done;

  assign lsu_active   = lsu_req.awvalid | lsu_req.wvalid | lsu_req.arvalid;
  assign fetch_active = fetch_req.awvalid | fetch_req.wvalid | fetch_req.arvalid;

  // while idle the load/store unit wins, after that the owner register decides
  assign sel_lsu   = owned ? owner_lsu : lsu_active;
  assign sel_fetch = owned ? !owner_lsu : (!lsu_active && fetch_active);

  always_comb begin
    if (sel_lsu) begin
      mem_req = lsu_req;
    end else if (sel_fetch) begin
      mem_req = fetch_req;
    end else begin
      mem_req = '0;
    end
  end

  assign lsu_rsp   = sel_lsu ? mem_rsp : '0;
  assign fetch_rsp = sel_fetch ? mem_rsp : '0;

  assign resp_done = (mem_rsp.bvalid && mem_req.bready) ||
                     (mem_rsp.rvalid && mem_req.rready);

  always_ff @(posedge clock) begin
    if (reset) begin
      owned     <= 1'b0;
      owner_lsu <= 1'b0;
    end else if (owned) begin
      if (resp_done) begin
        owned <= 1'b0;
      end
    end else if (lsu_active || fetch_active) begin
      owned     <= 1'b1;
      owner_lsu <= lsu_active;
    end
  end

endmodule

//--- hdl/exec_unit.sv
module exec_unit (
  input  logic          clock,
  input  logic          reset,
  output logic          fetch_next,
  output logic [31:0]   next_pc,
  input  logic          inst_valid,
  input  rv_pkg::inst_t inst,
  output logic [3:0]    rs1,
  output logic [3:0]    rs2,
  output logic [3:0]    rd,
  output logic          wen,
  output logic [31:0]   wdata,
  input  logic [31:0]   src1,
  input  logic [31:0]   src2,
  output logic [11:0]   csr_addr,
  input  logic [31:0]   csr_rdata,
  output logic          csr_wen,
  output logic [31:0]   csr_wdata,
  output logic          trap,
  output logic [31:0]   trap_cause,
  output logic [31:0]   trap_pc,
  input  logic [31:0]   mtvec,
  input  logic [31:0]   mepc,
  output logic          mem_start,
  output logic          mem_write,
  output logic [31:0]   mem_addr,
  output logic [31:0]   mem_wdata,
  input  logic          mem_done,
  input  logic [31:0]   mem_rdata,
  output logic          halted
);

  logic [2:0]    state;
  logic [31:0]   pc;
  rv_pkg::inst_t ir;
  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [31:0]   imm_i;
  logic [31:0]   imm_s;
  logic [31:0]   imm_b;
  logic [31:0]   imm_u;
  logic [31:0]   imm_j;
  logic [31:0]   result;
  logic [31:0]   target;
  logic [31:0]   new_pc;
  logic          writes_rd;
  logic          jumps;
  logic          misaligned;
  logic          is_sys;
  logic          is_ecall;
  logic          is_ebreak;
  logic          is_mret;
  logic          is_mem;
  logic          in_exec;

  assign opcode = ir.r.opcode;
  assign funct3 = ir.r.funct3;

  assign imm_i = {{20{ir.i.imm[11]}}, ir.i.imm};
  assign imm_s = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
  assign imm_b = {{19{ir.b.imm12}}, ir.b.imm12, ir.b.imm11, ir.b.imm10_5, ir.b.imm4_1, 1'b0};
  assign imm_u = {ir.u.imm, 12'd0};
  assign imm_j = {{11{ir.j.imm20}}, ir.j.imm20, ir.j.imm19_12, ir.j.imm11, ir.j.imm10_1, 1'b0};

  assign in_exec   = state == rv_pkg::st_exec;
  assign is_sys    = opcode == rv_pkg::op_system && funct3 == 3'd0;
  assign is_ecall  = is_sys && ir.i.imm == 12'h000;
  assign is_ebreak = is_sys && ir.i.imm == 12'h001;
  assign is_mret   = is_sys && ir.i.imm == 12'h302;
  assign is_mem    = opcode == rv_pkg::op_load || opcode == rv_pkg::op_store;

  assign rs1      = ir.r.rs1[3:0];
  assign rs2      = ir.r.rs2[3:0];
  assign rd       = ir.r.rd[3:0];
  assign csr_addr = ir.i.imm;

  always_comb begin
    result    = pc + 32'd4;
    target    = pc + 32'd4;
    writes_rd = 1'b0;
    jumps     = 1'b0;
    case (opcode)
      rv_pkg::op_reg: begin
        result    = ir.r.funct7[5] ? src1 - src2 : src1 + src2;
        writes_rd = 1'b1;
      end
      rv_pkg::op_imm: begin
        result    = src1 + imm_i;
        writes_rd = 1'b1;
      end
      rv_pkg::op_lui: begin
        result    = imm_u;
        writes_rd = 1'b1;
      end
      rv_pkg::op_jal: begin
        target    = pc + imm_j;
        jumps     = 1'b1;
        writes_rd = 1'b1;
      end
      // bit 0 is kept so that an odd target traps
      rv_pkg::op_jalr: begin
        target    = src1 + imm_i;
        jumps     = 1'b1;
        writes_rd = 1'b1;
      end
      rv_pkg::op_branch: begin
        target = pc + imm_b;
        jumps  = funct3[0] ? (src1 != src2) : (src1 == src2);
      end
      rv_pkg::op_system: begin
        result    = csr_rdata;
        writes_rd = funct3 != 3'd0;
      end
      default: ;
    endcase
  end

  assign misaligned = jumps && target[1:0] != 2'b00;

  assign trap       = in_exec && (is_ecall || misaligned);
  assign trap_cause = is_ecall ? rv_pkg::cause_ecall : rv_pkg::cause_misaligned;
  assign trap_pc    = pc;

  // csrrs with x0 as source only reads
  assign csr_wen   = in_exec && opcode == rv_pkg::op_system &&
                     (funct3 == 3'd1 || (funct3 == 3'd2 && ir.r.rs1 != 5'd0));
  assign csr_wdata = funct3[1] ? (csr_rdata | src1) : src1;

  assign wen   = (in_exec && writes_rd && !misaligned) ||
                 (state == rv_pkg::st_mem && mem_done && opcode == rv_pkg::op_load);
  assign wdata = (state == rv_pkg::st_mem) ? mem_rdata : result;

  assign mem_start = in_exec && is_mem;
  assign mem_write = opcode == rv_pkg::op_store;
  assign mem_addr  = src1 + (mem_write ? imm_s : imm_i);
  assign mem_wdata = src2;

  assign fetch_next = state == rv_pkg::st_issue;
  assign next_pc    = pc;
  assign halted     = state == rv_pkg::st_halt;

  always_comb begin
    if (trap) begin
      new_pc = mtvec;
    end else if (is_mret) begin
      new_pc = mepc;
    end else if (jumps) begin
      new_pc = target;
    end else begin
      new_pc = pc + 32'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= rv_pkg::st_issue;
      pc    <= rv_pkg::reset_pc;
    end else begin
      case (state)
        rv_pkg::st_issue: state <= rv_pkg::st_inst;
        rv_pkg::st_inst: begin
          if (inst_valid) begin
            state <= rv_pkg::st_exec;
          end
        end
        rv_pkg::st_exec: begin
          pc <= new_pc;
          if (is_ebreak) begin
            state <= rv_pkg::st_halt;
          end else if (is_mem) begin
            state <= rv_pkg::st_mem;
          end else begin
            state <= rv_pkg::st_issue;
          end
        end
        rv_pkg::st_mem: begin
          if (mem_done) begin
            state <= rv_pkg::st_issue;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (inst_valid) begin
      ir <= inst;
    end
  end

endmodule

//--- hdl/rv_core.sv
module rv_core (
  input  logic             clock,
  input  logic             reset,
  output rv_pkg::axi_req_t mem_req,
  input  rv_pkg::axi_rsp_t mem_rsp,
  output logic             halted
);

  rv_pkg::axi_req_t fetch_req;
  rv_pkg::axi_rsp_t fetch_rsp;
  rv_pkg::axi_req_t lsu_req;
  rv_pkg::axi_rsp_t lsu_rsp;
  rv_pkg::inst_t    inst;
  logic             fetch_next;
  logic [31:0]      next_pc;
  logic             inst_valid;
  logic [3:0]       rs1;
  logic [3:0]       rs2;
  logic [3:0]       rd;
  logic             wen;
  logic [31:0]      wdata;
  logic [31:0]      src1;
  logic [31:0]      src2;
  logic [11:0]      csr_addr;
  logic [31:0]      csr_rdata;
  logic             csr_wen;
  logic [31:0]      csr_wdata;
  logic             trap;
  logic [31:0]      trap_cause;
  logic [31:0]      trap_pc;
  logic [31:0]      mtvec;
  logic [31:0]      mepc;
  logic             mem_start;
  logic             mem_write;
  logic [31:0]      mem_addr;
  logic [31:0]      mem_wdata;
  logic             mem_done;
  logic [31:0]      mem_rdata;

  reg_file i_reg_file (
    .clock      (clock),
    .reset      (reset),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .wen        (wen),
    .wdata      (wdata),
    .src1       (src1),
    .src2       (src2),
    .csr_addr   (csr_addr),
    .csr_rdata  (csr_rdata),
    .csr_wen    (csr_wen),
    .csr_wdata  (csr_wdata),
    .trap       (trap),
    .trap_cause (trap_cause),
    .trap_pc    (trap_pc),
    .mtvec      (mtvec),
    .mepc       (mepc)
  );

  fetch_unit i_fetch_unit (
    .clock      (clock),
    .reset      (reset),
    .fetch_next (fetch_next),
    .next_pc    (next_pc),
    .inst_valid (inst_valid),
    .inst       (inst),
    .bus_req    (fetch_req),
    .bus_rsp    (fetch_rsp)
  );

  load_store_unit i_load_store_unit (
    .clock     (clock),
    .reset     (reset),
    .mem_start (mem_start),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata),
    .bus_req   (lsu_req),
    .bus_rsp   (lsu_rsp)
  );

  axi_lite_arbiter i_axi_lite_arbiter (
    .clock     (clock),
    .reset     (reset),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .lsu_req   (lsu_req),
    .lsu_rsp   (lsu_rsp),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

  exec_unit i_exec_unit (
    .clock      (clock),
    .reset      (reset),
    .fetch_next (fetch_next),
    .next_pc    (next_pc),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .wen        (wen),
    .wdata      (wdata),
    .src1       (src1),
    .src2       (src2),
    .csr_addr   (csr_addr),
    .csr_rdata  (csr_rdata),
    .csr_wen    (csr_wen),
    .csr_wdata  (csr_wdata),
    .trap       (trap),
    .trap_cause (trap_cause),
    .trap_pc    (trap_pc),
    .mtvec      (mtvec),
    .mepc       (mepc),
    .mem_start  (mem_start),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_done   (mem_done),
    .mem_rdata  (mem_rdata),
    .halted     (halted)
  );

endmodule

//--- bench/tb_rv_core.sv
module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int period_ns = 4;
  localparam int n_tests = 6;
  localparam int cycles_per_test = 2000;
  // reset and the last bus beats add a few cycles to every test
  localparam int limit_ns = n_tests * (cycles_per_test + 20) * period_ns;

  localparam logic [31:0] ecall_word  = 32'h0000_0073;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;
  localparam logic [31:0] mret_word   = 32'h3020_0073;

  logic             clock;
  logic             reset;
  logic             in_reset;
  logic             halted;
  rv_pkg::axi_req_t mem_req;
  rv_pkg::axi_rsp_t mem_rsp;
  rv_pkg::axi_rsp_t rsp;

  logic [31:0] mem [256];
  logic [31:0] rng;
  logic [31:0] prog_addr [$];
  logic [31:0] prog_word [$];
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] load_ptr;
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic [1:0]  rd_cnt;
  logic [1:0]  wr_cnt;
  int          rd_phase;
  int          wr_phase;
  int          errors;
  int          bus_errors;
  int          failed;

  rv_core i_rv_core (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .halted  (halted)
  );

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  // reset as the DUT saw it on the last rising edge
  always_ff @(posedge clock) begin
    in_reset <= reset;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] add(input int rd, input int rs1, input int rs2);
    return {7'h00, rs2[4:0], rs1[4:0], 3'h0, rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] sub(input int rd, input int rs1, input int rs2);
    return {7'h20, rs2[4:0], rs1[4:0], 3'h0, rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'h0, rd[4:0], 7'h13};
  endfunction

  function automatic logic [31:0] lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'h2, rd[4:0], 7'h03};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'h2, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] beq(input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'h0, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] bne(input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'h1, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6F};
  endfunction

  function automatic logic [31:0] jalr(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'h0, rd[4:0], 7'h67};
  endfunction

  function automatic logic [31:0] csrrw(input int rd, input int csr, input int rs1);
    return {csr[11:0], rs1[4:0], 3'h1, rd[4:0], 7'h73};
  endfunction

  function automatic logic [31:0] csrrs(input int rd, input int csr, input int rs1);
    return {csr[11:0], rs1[4:0], 3'h2, rd[4:0], 7'h73};
  endfunction

  // AXI4-Lite memory with separate read and write channels and 0..3 cycle delays
  initial begin
    rsp = '0;
    mem_rsp = '0;
    rng = 32'h1133;
    bus_errors = 0;
    rd_phase = 0;
    wr_phase = 0;
    forever begin
      @(negedge clock);
      rsp = '0;
      if (in_reset) begin
        rd_phase = 0;
        wr_phase = 0;
        log_addr.delete();
        log_data.delete();
        foreach (mem[i]) mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};
        foreach (prog_addr[k]) mem[prog_addr[k][9:2]] = prog_word[k];
      end else begin
        if (rd_phase == 0 && mem_req.arvalid) begin
          rd_addr = mem_req.araddr;
          rng = lcg_next(rng);
          rd_cnt = rng[17:16];
          rd_phase = 1;
        end
        if (rd_phase == 1) begin
          assert (mem_req.arvalid) else begin
            $display("arvalid dropped before the read address was accepted");
            bus_errors++;
          end
          assert (mem_req.araddr == rd_addr) else begin
            $display("ERR araddr got %08h expected %08h", mem_req.araddr, rd_addr);
            bus_errors++;
          end
          if (rd_cnt == 2'd0) begin
            rsp.arready = 1'b1;
            rng = lcg_next(rng);
            rd_cnt = rng[17:16];
            rd_phase = 2;
          end else begin
            rd_cnt = rd_cnt - 2'd1;
          end
        end else if (rd_phase == 2) begin
          if (rd_cnt == 2'd0) begin
            rsp.rvalid = 1'b1;
            rsp.rdata = mem[rd_addr[9:2]];
            if (mem_req.rready) begin
              rd_phase = 0;
            end
          end else begin
            rd_cnt = rd_cnt - 2'd1;
          end
        end

        if (wr_phase == 0 && (mem_req.awvalid || mem_req.wvalid)) begin
          wr_addr = mem_req.awaddr;
          rng = lcg_next(rng);
          wr_cnt = rng[17:16];
          wr_phase = 1;
        end
        if (wr_phase == 1) begin
          assert (mem_req.awaddr == wr_addr) else begin
            $display("ERR awaddr got %08h expected %08h", mem_req.awaddr, wr_addr);
            bus_errors++;
          end
          if (wr_cnt == 2'd0) begin
            assert (mem_req.awvalid && mem_req.wvalid) else begin
              $display("write address and write data were not valid together");
              bus_errors++;
            end
            assert (mem_req.wstrb == 4'hF) else begin
              $display("ERR wstrb got %01h expected %01h", mem_req.wstrb, 4'hF);
              bus_errors++;
            end
            rsp.awready = 1'b1;
            rsp.wready = 1'b1;
            mem[wr_addr[9:2]] = mem_req.wdata;
            log_addr.push_back(wr_addr);
            log_data.push_back(mem_req.wdata);
            rng = lcg_next(rng);
            wr_cnt = rng[17:16];
            wr_phase = 2;
          end else begin
            wr_cnt = wr_cnt - 2'd1;
          end
        end else if (wr_phase == 2) begin
          if (wr_cnt == 2'd0) begin
            rsp.bvalid = 1'b1;
            if (mem_req.bready) begin
              wr_phase = 0;
            end
          end else begin
            wr_cnt = wr_cnt - 2'd1;
          end
        end
      end
      mem_rsp = rsp;
    end
  end

  initial begin
    #(limit_ns);
    $display("watchdog: run still going after %0d ns", limit_ns);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic new_program();
    prog_addr.delete();
    prog_word.delete();
    exp_addr.delete();
    exp_data.delete();
    load_ptr = 32'd0;
  endtask

  task automatic origin(input logic [31:0] addr);
    load_ptr = addr;
  endtask

  task automatic emit(input logic [31:0] word);
    prog_addr.push_back(load_ptr);
    prog_word.push_back(word);
    load_ptr = load_ptr + 32'd4;
  endtask

  task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic compare_writes();
    assert (log_addr.size() == exp_addr.size()) else begin
      $display("ERR write count got %0h expected %0h", log_addr.size(), exp_addr.size());
      errors++;
    end
    for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
      assert (log_addr[i] == exp_addr[i]) else begin
        $display("ERR awaddr[%0d] got %08h expected %08h", i, log_addr[i], exp_addr[i]);
        errors++;
      end
      assert (log_data[i] == exp_data[i]) else begin
        $display("ERR wdata[%0d] got %08h expected %08h", i, log_data[i], exp_data[i]);
        errors++;
      end
    end
  endtask

  task automatic run_and_check(input int num, input string name);
    int cycles;
    int errors_at_start;
    errors_at_start = errors + bus_errors;
    cycles = 0;
    @(negedge clock);
    reset = 1'b1;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    assert (!halted) else begin
      $display("halted is high right after reset");
      errors++;
    end
    assert (!mem_req.arvalid && !mem_req.awvalid && !mem_req.wvalid) else begin
      $display("a bus valid is high right after reset");
      errors++;
    end
    while (!halted && cycles < cycles_per_test) begin
      @(negedge clock);
      cycles++;
    end
    assert (halted) else begin
      $display("core did not halt within %0d cycles", cycles_per_test);
      errors++;
    end
    if (halted) begin
      compare_writes();
    end
    if (errors + bus_errors == errors_at_start) begin
      $display("test %0d %s: ok after %0d cycles", num, name, cycles);
    end else begin
      $display("test %0d %s: FAILED", num, name);
      failed++;
    end
  endtask

  task automatic arith_test();
    logic [31:0] x1;
    logic [31:0] x2;
    new_program();
    emit(lui(1, 'h12345));
    emit(addi(2, 0, 'h678));
    emit(add(3, 1, 2));
    emit(sub(4, 2, 1));
    emit(addi(5, 3, -1));
    emit(addi(6, 0, 'h200));
    emit(sw(1, 6, 0));
    emit(sw(3, 6, 4));
    emit(sw(4, 6, 8));
    emit(sw(5, 6, 12));
    emit(ebreak_word);
    x1 = 32'h12345 << 12;
    x2 = 32'h678;
    expect_write(32'h200, x1);
    expect_write(32'h204, x1 + x2);
    // sub and a negative addi wrap modulo 2^32
    expect_write(32'h208, x2 - x1);
    expect_write(32'h20C, x1 + x2 + 32'hFFFF_FFFF);
    run_and_check(1, "arithmetic");
  endtask

  task automatic load_store_test();
    logic [31:0] first;
    new_program();
    emit(addi(6, 0, 'h200));
    emit(addi(1, 0, 'h5A5));
    emit(sw(1, 6, 0));
    emit(lw(2, 6, 0));
    emit(addi(2, 2, 'h10));
    emit(sw(2, 6, 4));
    emit(lw(3, 6, 4));
    emit(sub(4, 3, 1));
    emit(sw(4, 6, 8));
    emit(ebreak_word);
    first = 32'h5A5;
    expect_write(32'h200, first);
    expect_write(32'h204, first + 32'h10);
    expect_write(32'h208, (first + 32'h10) - first);
    run_and_check(2, "load and store");
  endtask

  task automatic branch_test();
    logic [31:0] limit;
    new_program();
    emit(addi(6, 0, 'h200));
    emit(addi(1, 0, 0));
    emit(addi(2, 0, 5));
    emit(addi(1, 1, 1));
    emit(bne(1, 2, -4));
    emit(beq(1, 2, 8));
    emit(sw(0, 6, 0));
    emit(sw(1, 6, 4));
    // jal at 0x20 skips one store and links 0x24
    emit(jal(3, 8));
    emit(sw(2, 6, 8));
    emit(sw(3, 6, 12));
    emit(ebreak_word);
    limit = 32'd5;
    expect_write(32'h204, limit);
    expect_write(32'h20C, 32'h20 + 32'd4);
    run_and_check(3, "branches");
  endtask

  task automatic ecall_test();
    new_program();
    emit(addi(6, 0, 'h200));
    emit(addi(1, 0, 'h40));
    emit(csrrw(0, 'h305, 1));
    emit(ecall_word);
    emit(addi(2, 0, 7));
    emit(sw(2, 6, 8));
    emit(ebreak_word);
    // handler returns past the ecall
    origin(32'h40);
    emit(csrrs(3, 'h341, 0));
    emit(csrrs(4, 'h342, 0));
    emit(sw(3, 6, 0));
    emit(sw(4, 6, 4));
    emit(addi(3, 3, 4));
    emit(csrrw(0, 'h341, 3));
    emit(mret_word);
    expect_write(32'h200, 32'hC);
    expect_write(32'h204, 32'd11);
    expect_write(32'h208, 32'd7);
    run_and_check(4, "ecall trap");
  endtask

  task automatic misaligned_jump_test();
    new_program();
    emit(addi(6, 0, 'h200));
    emit(addi(1, 0, 'h40));
    emit(csrrw(0, 'h305, 1));
    // a nonzero mcause makes the cause 0 update visible
    emit(csrrw(0, 'h342, 1));
    emit(addi(5, 0, 3));
    emit(addi(2, 0, 'h21));
    emit(jalr(5, 2, 0));
    emit(ebreak_word);
    origin(32'h40);
    emit(csrrs(3, 'h341, 0));
    emit(csrrs(4, 'h342, 0));
    emit(sw(3, 6, 0));
    emit(sw(4, 6, 4));
    emit(sw(5, 6, 8));
    emit(ebreak_word);
    expect_write(32'h200, 32'h18);
    expect_write(32'h204, 32'd0);
    expect_write(32'h208, 32'd3);
    run_and_check(5, "misaligned jalr");
  endtask

  task automatic csr_read_test();
    new_program();
    emit(addi(6, 0, 'h200));
    emit(csrrs(1, 'hF11, 0));
    emit(csrrs(2, 'hF12, 0));
    emit(csrrs(3, 'h300, 0));
    emit(sw(1, 6, 0));
    emit(sw(2, 6, 4));
    emit(sw(3, 6, 8));
    emit(ebreak_word);
    expect_write(32'h200, rv_pkg::vendor_id);
    expect_write(32'h204, rv_pkg::arch_id);
    expect_write(32'h208, 32'h1800);
    run_and_check(6, "csr reads");
  endtask

  initial begin
    reset = 1'b1;
    errors = 0;
    failed = 0;
    load_ptr = 32'd0;
    arith_test();
    load_store_test();
    branch_test();
    ecall_test();
    misaligned_jump_test();
    csr_read_test();
    $display("tests %0d, failed %0d, errors %0d", n_tests, failed, errors + bus_errors);
    if (failed == 0 && errors + bus_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/axi_lite_arbiter.sv
hdl/exec_unit.sv
hdl/rv_core.sv
bench/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_rv_core -f build.f -o tb_rv_core
./obj_dir/tb_rv_core | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run_sim: failure reported in sim.log"
  exit 1
fi
echo "run_sim: no failure found in sim.log"
